// ==== source/dly_cfg_pkg.sv ====
//********************
// delay bank sizing
// lane count, tap range and history length
//********************

package dly_cfg_pkg;

    // lane count, split evenly between input and output paths
    localparam int NUM_DLY  = 12;
    localparam int NUM_HALF = NUM_DLY / 2;

    //********************
    // tap range
    //********************
    localparam int TAP_WIDTH = 6;
    localparam int MAX_TAP   = (1 << TAP_WIDTH) - 1;   // 63

    // wide enough to address every lane
    localparam int SEL_WIDTH = $clog2(NUM_DLY);

    // one history bit per tap position
    localparam int HIST_DEPTH = MAX_TAP + 1;

endpackage

// ==== source/dly_types_pkg.sv ====
//********************
// delay bank types
// tap, select, data vectors and control words
//********************

package dly_types_pkg;

    typedef logic [dly_cfg_pkg::TAP_WIDTH-1:0] tap_t;
    typedef logic [dly_cfg_pkg::SEL_WIDTH-1:0] sel_t;

    //********************
    // data vectors
    //********************
    typedef logic [dly_cfg_pkg::NUM_DLY-1:0]  data_vec_t;   // one bit per lane
    typedef logic [dly_cfg_pkg::NUM_HALF-1:0] half_vec_t;   // one bit per lane of a path

    //********************
    // control pulses
    //********************
    typedef struct packed {
        logic ld;       // load tap from load_tap
        logic adj;      // one step
        logic incdec;   // 1 up, 0 down
    } dly_ctrl_t;

    // per-lane control, element n goes to lane n
    typedef dly_ctrl_t [dly_cfg_pkg::NUM_DLY-1:0] lane_ctrl_t;

endpackage

// ==== source/dly_ctrl_decoder.sv ====
//********************
// delay control decoder
// registers the control pulses and the load value,
// steers the pulses to the selected lane only
//********************

`timescale 1ns/1ps

module dly_ctrl_decoder (
    input  logic                      clk_i,
    input  logic                      rst,
    input  dly_types_pkg::sel_t       sel_dly,
    input  dly_types_pkg::dly_ctrl_t  ctrl,
    input  dly_types_pkg::tap_t       load_tap,
    output dly_types_pkg::lane_ctrl_t lane_ctrl,
    output dly_types_pkg::tap_t       lane_tap
);

    dly_types_pkg::lane_ctrl_t             lane_ctrl_nxt;
    logic [dly_cfg_pkg::NUM_DLY-1:0]       lane_busy;   // any pulse on lane n

    //********************
    // select decode
    //********************
    always_comb begin
        lane_ctrl_nxt = '0;
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) begin
            // selects 12..15 never match, so those pulses are dropped
            if (sel_dly == dly_types_pkg::sel_t'(n)) begin
                lane_ctrl_nxt[n] = ctrl;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            lane_ctrl <= '0;
        end else begin
            lane_ctrl <= lane_ctrl_nxt;
        end
    end

    // load value travels alongside the pulses
    always_ff @(posedge clk_i) begin
        lane_tap <= load_tap;
    end

    //********************
    // checks
    //********************
    always_comb begin
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) begin
            lane_busy[n] = |lane_ctrl[n];
        end
    end

    // only the selected lane ever sees a pulse
    a_one_lane: assert property (
        @(posedge clk_i) disable iff (rst)
        $onehot0(lane_busy)
    ) else $error("control pulse reached more than one lane");

endmodule

// ==== source/dly_lane.sv ====
//********************
// single delay lane
// tap register with load and saturating step,
// data delayed by tap + 1 clocks
//********************

`timescale 1ns/1ps

module dly_lane (
    input  logic                     clk_i,
    input  logic                     rst,
    input  dly_types_pkg::dly_ctrl_t lane_ctrl,
    input  dly_types_pkg::tap_t      lane_tap,
    input  logic                     din,
    output dly_types_pkg::tap_t      tap,
    output logic                     dout
);

    logic [dly_cfg_pkg::HIST_DEPTH-1:0] hist;   // hist[0] is the newest bit
    logic                               at_max;
    logic                               at_min;

    assign at_max = (tap == dly_types_pkg::tap_t'(dly_cfg_pkg::MAX_TAP));
    assign at_min = (tap == '0);

    //********************
    // tap register
    //********************
    always_ff @(posedge clk_i) begin
        if (rst) begin
            tap <= '0;
        end else if (lane_ctrl.ld) begin
            tap <= lane_tap;                // load wins over adj
        end else if (lane_ctrl.adj) begin
            if (lane_ctrl.incdec) begin
                if (!at_max) begin
                    tap <= tap + 1'b1;
                end
            end else if (!at_min) begin
                tap <= tap - 1'b1;
            end
        end
    end

    //********************
    // data history
    //********************
    always_ff @(posedge clk_i) begin
        if (rst) begin
            hist <= '0;
            dout <= 1'b0;
        end else begin
            hist <= {hist[dly_cfg_pkg::HIST_DEPTH-2:0], din};
            // tap 0 picks last edge's sample, so one clock minimum
            dout <= hist[tap];
        end
    end

    // step down at zero must hold
    a_floor: assert property (
        @(posedge clk_i) disable iff (rst)
        (lane_ctrl.adj && !lane_ctrl.ld && !lane_ctrl.incdec && at_min) |=> (tap == '0)
    ) else $error("tap wrapped below zero");

endmodule

// ==== source/dly_tap_readback.sv ====
//********************
// tap readback
// registered mux of the selected lane's tap
//********************

`timescale 1ns/1ps

module dly_tap_readback (
    input  logic                                             clk_i,
    input  logic                                             rst,
    input  dly_types_pkg::sel_t                              sel_dly,
    input  dly_types_pkg::tap_t [dly_cfg_pkg::NUM_DLY-1:0]   taps,
    output dly_types_pkg::tap_t                              dly_tap_val
);

    dly_types_pkg::tap_t tap_sel;
    logic                sel_valid;

    assign sel_valid = (int'(sel_dly) < dly_cfg_pkg::NUM_DLY);

    //********************
    // lane mux
    //********************
    always_comb begin
        if (sel_valid) begin
            tap_sel = taps[sel_dly];
        end else begin
            tap_sel = taps[0];              // unused selects fall back to lane 0
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            dly_tap_val <= '0;
        end else begin
            dly_tap_val <= tap_sel;
        end
    end

endmodule

// ==== source/dly_bank_top.sv ====
//********************
// delay bank top
// twelve delay lanes, even lanes on the input path,
// odd lanes on the output path, with tap readback
//********************

`timescale 1ns/1ps

module dly_bank_top (
    input  logic                     clk_i,
    input  logic                     rst,
    input  dly_types_pkg::sel_t      sel_dly,
    input  dly_types_pkg::dly_ctrl_t ctrl,
    input  dly_types_pkg::tap_t      load_tap,
    input  dly_types_pkg::half_vec_t din_idly,
    input  dly_types_pkg::half_vec_t din_odly,
    output dly_types_pkg::data_vec_t data_delayed,
    output dly_types_pkg::tap_t      dly_tap_val
);

    dly_types_pkg::lane_ctrl_t                             lane_ctrl;
    dly_types_pkg::tap_t                                   lane_tap;
    dly_types_pkg::tap_t [dly_cfg_pkg::NUM_DLY-1:0]        lane_taps;
    dly_types_pkg::data_vec_t                              lane_din;

    //********************
    // control decode
    //********************
    dly_ctrl_decoder u_decoder (
        .clk_i     (clk_i),
        .rst       (rst),
        .sel_dly   (sel_dly),
        .ctrl      (ctrl),
        .load_tap  (load_tap),
        .lane_ctrl (lane_ctrl),
        .lane_tap  (lane_tap)
    );

    //********************
    // lanes
    //********************
    for (genvar n = 0; n < dly_cfg_pkg::NUM_DLY; n++) begin : g_lane
        // interleave the two paths onto the lane index
        if (n % 2 == 0) begin : g_idly
            assign lane_din[n] = din_idly[n/2];
        end else begin : g_odly
            assign lane_din[n] = din_odly[n/2];
        end

        dly_lane u_lane (
            .clk_i     (clk_i),
            .rst       (rst),
            .lane_ctrl (lane_ctrl[n]),
            .lane_tap  (lane_tap),
            .din       (lane_din[n]),
            .tap       (lane_taps[n]),
            .dout      (data_delayed[n])
        );
    end

    //********************
    // readback
    //********************
    dly_tap_readback u_readback (
        .clk_i       (clk_i),
        .rst         (rst),
        .sel_dly     (sel_dly),
        .taps        (lane_taps),
        .dly_tap_val (dly_tap_val)
    );

endmodule

// ==== tb/tb_dly_bank.sv ====
//********************
// delay bank testbench
// directed tests against a reference model of taps and lane history
//********************

`timescale 1ns/1ps

module tb_dly_bank;

    localparam int HIST_KEEP = 128;   // model history, deeper than any tap + 1
    localparam int WAIT_MAX  = 100;   // polling steps before a wait gives up

    logic                      clk_i = 1'b0;
    logic                      rst;
    dly_types_pkg::sel_t       sel_dly;
    dly_types_pkg::dly_ctrl_t  ctrl;
    dly_types_pkg::tap_t       load_tap;
    dly_types_pkg::half_vec_t  din_idly;
    dly_types_pkg::half_vec_t  din_odly;
    dly_types_pkg::data_vec_t  data_delayed;
    dly_types_pkg::tap_t       dly_tap_val;

    dly_types_pkg::tap_t       ref_tap [dly_cfg_pkg::NUM_DLY];
    dly_types_pkg::data_vec_t  in_hist [HIST_KEEP];   // in_hist[0] is the newest sample
    logic [16:0]               lfsr = 17'd97854;
    int                        fall_cnt = 0;
    int                        tap_errs = 0;
    int                        data_errs = 0;
    int                        timeout_errs = 0;

    dly_bank_top DUT (
        .clk_i        (clk_i),
        .rst          (rst),
        .sel_dly      (sel_dly),
        .ctrl         (ctrl),
        .load_tap     (load_tap),
        .din_idly     (din_idly),
        .din_odly     (din_odly),
        .data_delayed (data_delayed),
        .dly_tap_val  (dly_tap_val)
    );

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    always @(negedge clk_i) fall_cnt++;

    //********************
    // stimulus helpers
    //********************
    // x^17 + x^14 + 1, one step per bit
    function automatic logic next_rand_bit();
        logic fb;
        fb   = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    // even lanes from the input path, odd lanes from the output path
    function automatic dly_types_pkg::data_vec_t lanes_of(dly_types_pkg::half_vec_t iv,
                                                          dly_types_pkg::half_vec_t ov);
        dly_types_pkg::data_vec_t v;
        for (int i = 0; i < dly_cfg_pkg::NUM_HALF; i++) begin
            v[2*i]   = iv[i];
            v[2*i+1] = ov[i];
        end
        return v;
    endfunction

    function automatic dly_types_pkg::tap_t exp_readback(int sel);
        return (sel < dly_cfg_pkg::NUM_DLY) ? ref_tap[sel] : ref_tap[0];
    endfunction

    // one full clock, returns just after the falling edge
    task automatic tick();
        int start;
        int waited;
        start  = fall_cnt;
        waited = 0;
        while (fall_cnt == start && waited < WAIT_MAX) begin
            #1;
            waited++;
        end
        if (fall_cnt == start) begin
            $display("clock edge never arrived within %0d ns", WAIT_MAX);
            timeout_errs++;
        end
        for (int i = HIST_KEEP - 1; i > 0; i--) in_hist[i] = in_hist[i-1];
        in_hist[0] = lanes_of(din_idly, din_odly);   // what the last rising edge sampled
    endtask

    //********************
    // compare tasks
    //********************
    task automatic check_tap(string name, dly_types_pkg::tap_t exp, dly_types_pkg::tap_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            tap_errs++;
        end
    endtask

    task automatic check_data(string name, dly_types_pkg::data_vec_t exp,
                              dly_types_pkg::data_vec_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            data_errs++;
        end
    endtask

    // one-cycle control pulse, model follows the lane rules
    task automatic pulse(int sel, logic ld, logic adj, logic up, dly_types_pkg::tap_t val);
        sel_dly    = dly_types_pkg::sel_t'(sel);
        ctrl.ld    = ld;
        ctrl.adj   = adj;
        ctrl.incdec = up;
        load_tap   = val;
        tick();
        ctrl = '0;
        if (sel < dly_cfg_pkg::NUM_DLY) begin
            if (ld) begin
                ref_tap[sel] = val;
            end else if (adj && up &&
                         ref_tap[sel] != dly_types_pkg::tap_t'(dly_cfg_pkg::MAX_TAP)) begin
                ref_tap[sel] = ref_tap[sel] + 1'b1;
            end else if (adj && !up && ref_tap[sel] != '0) begin
                ref_tap[sel] = ref_tap[sel] - 1'b1;
            end
        end
    endtask

    task automatic read_tap(int sel);
        sel_dly = dly_types_pkg::sel_t'(sel);
        tick();
        tick();   // covers a pulse still on its way to the lane
        check_tap("dly_tap_val", exp_readback(sel), dly_tap_val);
    endtask

    //********************
    // directed tests
    //********************
    task automatic test_reset_state();
        check_data("data_delayed", '0, data_delayed);
        for (int s = 0; s < 16; s++) read_tap(s);
    endtask

    task automatic test_load_readback();
        dly_types_pkg::tap_t old_tap;
        dly_types_pkg::tap_t val;
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) begin
            old_tap = ref_tap[n];
            val     = dly_types_pkg::tap_t'(rand_bits(dly_cfg_pkg::TAP_WIDTH));
            pulse(n, 1'b1, 1'b0, 1'b0, val);
            tick();
            check_tap("dly_tap_val", old_tap, dly_tap_val);   // one edge after, still old
            tick();
            check_tap("dly_tap_val", val, dly_tap_val);
        end
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) read_tap(n);
    endtask

    task automatic test_delay();
        dly_types_pkg::data_vec_t exp;
        pulse(0, 1'b1, 1'b0, 1'b0, 6'd0);
        pulse(1, 1'b1, 1'b0, 1'b0, 6'd63);
        pulse(2, 1'b1, 1'b0, 1'b0, 6'd5);
        pulse(3, 1'b1, 1'b0, 1'b0, 6'd17);
        tick();
        tick();
        for (int c = 0; c < 90; c++) begin
            din_idly = dly_types_pkg::half_vec_t'(rand_bits(dly_cfg_pkg::NUM_HALF));
            din_odly = dly_types_pkg::half_vec_t'(rand_bits(dly_cfg_pkg::NUM_HALF));
            tick();
            for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) begin
                exp[n] = in_hist[1 + int'(ref_tap[n])][n];
            end
            check_data("data_delayed", exp, data_delayed);
        end
        din_idly = '0;
        din_odly = '0;
    endtask

    task automatic test_step_saturation();
        pulse(4, 1'b1, 1'b0, 1'b0, 6'd62);
        for (int i = 0; i < 3; i++) pulse(4, 1'b0, 1'b1, 1'b1, 6'd0);   // back to back
        read_tap(4);
        pulse(5, 1'b1, 1'b0, 1'b0, 6'd1);
        for (int i = 0; i < 3; i++) pulse(5, 1'b0, 1'b1, 1'b0, 6'd0);
        read_tap(5);
        pulse(6, 1'b1, 1'b1, 1'b1, 6'd10);   // load beats the step
        read_tap(6);
    endtask

    task automatic test_bad_select();
        pulse(0, 1'b1, 1'b0, 1'b0, 6'd42);   // nonzero lane 0 tap, unlike the reset value
        for (int s = dly_cfg_pkg::NUM_DLY; s < 16; s++) begin
            pulse(s, 1'b1, 1'b0, 1'b0, dly_types_pkg::tap_t'(rand_bits(dly_cfg_pkg::TAP_WIDTH)));
            pulse(s, 1'b0, 1'b1, 1'b1, 6'd0);
            read_tap(s);
        end
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) read_tap(n);
    endtask

    //********************
    // main sequence
    //********************
    initial begin
        rst      = 1'b1;
        sel_dly  = '0;
        ctrl     = '0;
        load_tap = '0;
        din_idly = '0;
        din_odly = '0;
        for (int n = 0; n < dly_cfg_pkg::NUM_DLY; n++) ref_tap[n] = '0;
        for (int i = 0; i < HIST_KEEP; i++) in_hist[i] = '0;
        for (int i = 0; i < 4; i++) tick();
        rst = 1'b0;
        for (int i = 0; i < HIST_KEEP; i++) in_hist[i] = '0;

        test_reset_state();
        test_load_readback();
        test_delay();
        test_step_saturation();
        test_bad_select();

        $display("errors: tap %0d, data %0d, timeout %0d", tap_errs, data_errs, timeout_errs);
        if (tap_errs + data_errs + timeout_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/dly_cfg_pkg.sv
source/dly_types_pkg.sv
source/dly_ctrl_decoder.sv
source/dly_lane.sv
source/dly_tap_readback.sv
source/dly_bank_top.sv
tb/tb_dly_bank.sv

// ==== Makefile ====
# Verilator build and run for the delay bank testbench
#
#   make compile   build the simulation binary
#   make run       run it and check the log for the pass message
#   make clean     remove build output and log
#
# every variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_dly_bank
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN := $(BUILD_DIR)/$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) $(EXTRA) \
		-f $(FILELIST) \
		--top-module $(TOP) \
		-Mdir $(BUILD_DIR) \
		-o $(TOP)

# the log decides pass or fail, not the exit code of the binary
run: compile
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
